//--- Bender.yml
package:
  name: cordic_rotator

export_include_dirs:
  - source

sources:
  - include_dirs:
      - source
    files:
      - source/cordic_pkg.sv
      - source/cordic_quadrant_stage.sv
      - source/cordic_friendly_stage.sv
      - source/cordic_usr_stage.sv
      - source/cordic_nominal_stage.sv
      - source/cordic_micro_stage.sv
      - source/cordic_sign_fix.sv
      - source/cordic_rotator.sv
  - target: test
    include_dirs:
      - source
      - tests
    files:
      - tests/cordic_rotator_tb.sv

//--- list.f
+incdir+source
+incdir+tests
source/cordic_pkg.sv
source/cordic_quadrant_stage.sv
source/cordic_friendly_stage.sv
source/cordic_usr_stage.sv
source/cordic_nominal_stage.sv
source/cordic_micro_stage.sv
source/cordic_sign_fix.sv
source/cordic_rotator.sv
tests/cordic_rotator_tb.sv

//--- source/cordic_friendly_stage.sv
`timescale 1ns/1ps
`include "cordic_settings.svh"

module cordic_friendly_stage (
    input  logic              clk,
    input  logic              rst_n,
    input  cordic_pkg::vec_t  in_vec,
    output cordic_pkg::vec_t  out_vec
);

    logic signed [`CORDIC_W-1:0] coef_a;
    logic signed [`CORDIC_W-1:0] coef_b;
    logic signed [`CORDIC_W-1:0] atan;
    cordic_pkg::vec_t            next_vec;

    ////////////////////
    // Triple selection by |z| band
    ////////////////////
    always_comb
    begin
        if (in_vec.z < -`CORDIC_FA_T2 || in_vec.z >= `CORDIC_FA_T2)
        begin
            coef_a = 20;
            coef_b = 15;
            atan   = `CORDIC_FA_ATAN2;
        end
        else if (in_vec.z < -`CORDIC_FA_T1 || in_vec.z >= `CORDIC_FA_T1)
        begin
            coef_a = 24;
            coef_b = 7;
            atan   = `CORDIC_FA_ATAN1;
        end
        else
        begin
            // Plain scale by 25 keeps gain equal across bands
            coef_a = 25;
            coef_b = 0;
            atan   = 0;
        end
    end

    // Rotate against the sign of z
    always_comb
    begin
        next_vec.valid = in_vec.valid;
        next_vec.angle = in_vec.angle;
        if (in_vec.z < 0)
        begin
            next_vec.x = coef_a * in_vec.x - coef_b * in_vec.y;
            next_vec.y = coef_a * in_vec.y + coef_b * in_vec.x;
            next_vec.z = in_vec.z + atan;
        end
        else
        begin
            next_vec.x = coef_a * in_vec.x + coef_b * in_vec.y;
            next_vec.y = coef_a * in_vec.y - coef_b * in_vec.x;
            next_vec.z = in_vec.z - atan;
        end
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            out_vec <= '0;
        end
        else
        begin
            out_vec <= next_vec;
        end
    end

endmodule

//--- source/cordic_micro_stage.sv
`timescale 1ns/1ps
`include "cordic_settings.svh"

module cordic_micro_stage #(
    parameter int SHIFT = `CORDIC_MICRO_SHIFT,
    parameter int ATAN  = `CORDIC_MICRO_ATAN
) (
    input  logic              clk,
    input  logic              rst_n,
    input  cordic_pkg::vec_t  in_vec,
    output cordic_pkg::vec_t  out_vec
);

    logic [`CORDIC_W:0] z_abs2;
    logic [3:0]         m_mag;
    logic signed [4:0]  m;
    cordic_pkg::vec_t   next_vec;

    ////////////////////
    // Level select by nearest multiple of ATAN
    ////////////////////
    always_comb
    begin
        // Twice |z| so half steps compare as integers
        z_abs2 = in_vec.z[`CORDIC_W-1] ? {-in_vec.z, 1'b0} : {in_vec.z, 1'b0};
        m_mag  = '0;
        for (int k = 1; k <= 8; k++)
        begin
            if (z_abs2 >= (2 * k - 1) * ATAN)
            begin
                m_mag = 4'(k);
            end
        end
        m = in_vec.z[`CORDIC_W-1] ? -$signed({1'b0, m_mag}) : $signed({1'b0, m_mag});
    end

    always_comb
    begin
        next_vec.valid = in_vec.valid;
        next_vec.angle = in_vec.angle;
        next_vec.x     = in_vec.x + m * (in_vec.y >>> SHIFT);
        next_vec.y     = in_vec.y - m * (in_vec.x >>> SHIFT);
        next_vec.z     = in_vec.z - m * ATAN;
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            out_vec <= '0;
        end
        else
        begin
            out_vec <= next_vec;
        end
    end

endmodule

//--- source/cordic_nominal_stage.sv
`timescale 1ns/1ps
`include "cordic_settings.svh"

module cordic_nominal_stage #(
    parameter int SHIFT = 5,
    parameter int ATAN  = `CORDIC_NOM_ATAN5
) (
    input  logic              clk,
    input  logic              rst_n,
    input  cordic_pkg::vec_t  in_vec,
    output cordic_pkg::vec_t  out_vec
);

    cordic_pkg::vec_t next_vec;

    always_comb
    begin
        next_vec.valid = in_vec.valid;
        next_vec.angle = in_vec.angle;
        if (in_vec.z < 0)
        begin
            next_vec.x = in_vec.x - (in_vec.y >>> SHIFT);
            next_vec.y = in_vec.y + (in_vec.x >>> SHIFT);
            next_vec.z = in_vec.z + ATAN;
        end
        else
        begin
            next_vec.x = in_vec.x + (in_vec.y >>> SHIFT);
            next_vec.y = in_vec.y - (in_vec.x >>> SHIFT);
            next_vec.z = in_vec.z - ATAN;
        end
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            out_vec <= '0;
        end
        else
        begin
            out_vec <= next_vec;
        end
    end

endmodule

//--- source/cordic_pkg.sv
`include "cordic_settings.svh"

package cordic_pkg;

    // Top-level input sample
    typedef struct packed {
        logic                            valid;
        logic signed [`CORDIC_IN_W-1:0]  x;
        logic signed [`CORDIC_IN_W-1:0]  y;
        logic signed [`CORDIC_IN_W-1:0]  angle;
    } sample_t;

    // Vector passed between stages with the untouched input angle
    typedef struct packed {
        logic                            valid;
        logic signed [`CORDIC_W-1:0]     x;
        logic signed [`CORDIC_W-1:0]     y;
        logic signed [`CORDIC_W-1:0]     z;
        logic signed [`CORDIC_IN_W-1:0]  angle;
    } vec_t;

    typedef struct packed {
        logic                            valid;
        logic signed [`CORDIC_W-1:0]     x;
        logic signed [`CORDIC_W-1:0]     y;
    } result_t;

endpackage

//--- source/cordic_quadrant_stage.sv
`timescale 1ns/1ps
`include "cordic_settings.svh"

module cordic_quadrant_stage (
    input  logic                 clk,
    input  logic                 rst_n,
    input  cordic_pkg::sample_t  in_sample,
    output cordic_pkg::vec_t     out_vec
);

    logic signed [`CORDIC_W-1:0] x_s;
    logic signed [`CORDIC_W-1:0] y_s;
    logic signed [`CORDIC_W-1:0] z_s;
    cordic_pkg::vec_t            next_vec;

    assign x_s = in_sample.x * `CORDIC_ANGLE_SCALE;
    assign y_s = in_sample.y * `CORDIC_ANGLE_SCALE;
    assign z_s = in_sample.angle * `CORDIC_ANGLE_SCALE;

    // Coarse rotation by multiples of 90 degrees from the angle alone
    always_comb
    begin
        next_vec.valid = in_sample.valid;
        next_vec.angle = in_sample.angle;
        if (in_sample.angle < -135)
        begin
            next_vec.x = -x_s;
            next_vec.y = -y_s;
            next_vec.z = z_s + `CORDIC_HALF;
        end
        else if (in_sample.angle < -45)
        begin
            next_vec.x = -y_s;
            next_vec.y = x_s;
            next_vec.z = z_s + `CORDIC_QUARTER;
        end
        else if (in_sample.angle < 45)
        begin
            next_vec.x = x_s;
            next_vec.y = y_s;
            next_vec.z = z_s;
        end
        else if (in_sample.angle < 135)
        begin
            next_vec.x = y_s;
            next_vec.y = -x_s;
            next_vec.z = z_s - `CORDIC_QUARTER;
        end
        else
        begin
            next_vec.x = -x_s;
            next_vec.y = -y_s;
            next_vec.z = z_s - `CORDIC_HALF;
        end
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            out_vec <= '0;
        end
        else
        begin
            out_vec <= next_vec;
        end
    end

endmodule

//--- source/cordic_rotator.sv
`timescale 1ns/1ps
`include "cordic_settings.svh"

module cordic_rotator (
    input  logic                 clk,
    input  logic                 rst_n,
    input  cordic_pkg::sample_t  in_sample,
    output cordic_pkg::result_t  out_result
);

    cordic_pkg::vec_t s_quad;
    cordic_pkg::vec_t s_friendly;
    cordic_pkg::vec_t s_usr;
    cordic_pkg::vec_t s_nom5;
    cordic_pkg::vec_t s_nom6;
    cordic_pkg::vec_t s_nom7;
    cordic_pkg::vec_t s_micro;

    ////////////////////
    // Coarse stages
    ////////////////////
    cordic_quadrant_stage u_quadrant (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_sample (in_sample),
        .out_vec   (s_quad)
    );

    cordic_friendly_stage u_friendly (
        .clk     (clk),
        .rst_n   (rst_n),
        .in_vec  (s_quad),
        .out_vec (s_friendly)
    );

    cordic_usr_stage u_usr (
        .clk     (clk),
        .rst_n   (rst_n),
        .in_vec  (s_friendly),
        .out_vec (s_usr)
    );

    ////////////////////
    // Fine stages
    ////////////////////
    cordic_nominal_stage #(.SHIFT(5), .ATAN(`CORDIC_NOM_ATAN5)) u_nom5 (
        .clk     (clk),
        .rst_n   (rst_n),
        .in_vec  (s_usr),
        .out_vec (s_nom5)
    );

    cordic_nominal_stage #(.SHIFT(6), .ATAN(`CORDIC_NOM_ATAN6)) u_nom6 (
        .clk     (clk),
        .rst_n   (rst_n),
        .in_vec  (s_nom5),
        .out_vec (s_nom6)
    );

    cordic_nominal_stage #(.SHIFT(7), .ATAN(`CORDIC_NOM_ATAN7)) u_nom7 (
        .clk     (clk),
        .rst_n   (rst_n),
        .in_vec  (s_nom6),
        .out_vec (s_nom7)
    );

    cordic_micro_stage #(
        .SHIFT (`CORDIC_MICRO_SHIFT),
        .ATAN  (`CORDIC_MICRO_ATAN)
    ) u_micro (
        .clk     (clk),
        .rst_n   (rst_n),
        .in_vec  (s_nom7),
        .out_vec (s_micro)
    );

    cordic_sign_fix u_sign (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_vec     (s_micro),
        .out_result (out_result)
    );

endmodule

//--- source/cordic_settings.svh
`ifndef CORDIC_SETTINGS_SVH
`define CORDIC_SETTINGS_SVH

// Widths
`define CORDIC_IN_W         9
`define CORDIC_W            32

// Angle units per degree, quadrant steps
`define CORDIC_ANGLE_SCALE  10000
`define CORDIC_QUARTER      900000
`define CORDIC_HALF         1800000

// Friendly angle stage
`define CORDIC_FA_T1        103050
`define CORDIC_FA_T2        265650
`define CORDIC_FA_ATAN1     162600
`define CORDIC_FA_ATAN2     368700

// Scaled single step
`define CORDIC_USR_T        35630
`define CORDIC_USR_ATAN     71250

// Nominal iterations with atan(2^-k) in angle units
`define CORDIC_NOM_ATAN5    17900
`define CORDIC_NOM_ATAN6    8950
`define CORDIC_NOM_ATAN7    4480

`define CORDIC_MICRO_SHIFT  10
`define CORDIC_MICRO_ATAN   560

// Register stages from input to result
`define CORDIC_LATENCY      8

`endif

//--- source/cordic_sign_fix.sv
`timescale 1ns/1ps
`include "cordic_settings.svh"

module cordic_sign_fix (
    input  logic                 clk,
    input  logic                 rst_n,
    input  cordic_pkg::vec_t     in_vec,
    output cordic_pkg::result_t  out_result
);

    logic signed [`CORDIC_W-1:0] x_pos;
    logic signed [`CORDIC_W-1:0] x_neg;
    logic signed [`CORDIC_W-1:0] y_pos;
    logic signed [`CORDIC_W-1:0] y_neg;
    cordic_pkg::result_t         next_result;

    assign x_pos = (in_vec.x < 0) ? -in_vec.x : in_vec.x;
    assign x_neg = (in_vec.x > 0) ? -in_vec.x : in_vec.x;
    assign y_pos = (in_vec.y < 0) ? -in_vec.y : in_vec.y;
    assign y_neg = (in_vec.y > 0) ? -in_vec.y : in_vec.y;

    // Quadrant of the original angle sets the signs
    always_comb
    begin
        next_result.valid = in_vec.valid;
        if (in_vec.angle <= -90)
        begin
            next_result.x = x_neg;
            next_result.y = y_neg;
        end
        else if (in_vec.angle <= 0)
        begin
            next_result.x = x_pos;
            next_result.y = y_neg;
        end
        else if (in_vec.angle <= 90)
        begin
            next_result.x = x_pos;
            next_result.y = y_pos;
        end
        else
        begin
            next_result.x = x_neg;
            next_result.y = y_pos;
        end
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            out_result <= '0;
        end
        else
        begin
            out_result <= next_result;
        end
    end

endmodule

//--- source/cordic_usr_stage.sv
`timescale 1ns/1ps
`include "cordic_settings.svh"

module cordic_usr_stage (
    input  logic              clk,
    input  logic              rst_n,
    input  cordic_pkg::vec_t  in_vec,
    output cordic_pkg::vec_t  out_vec
);

    // Shift-add gain trim ahead of the rotation
    function automatic logic signed [`CORDIC_W-1:0] pre_trim(
        input logic signed [`CORDIC_W-1:0] v
    );
        return (v >>> 5) + (v >>> 6) - (v >>> 8) - (v >>> 9) - (v >>> 10);
    endfunction

    logic signed [`CORDIC_W-1:0] x_t;
    logic signed [`CORDIC_W-1:0] y_t;
    logic signed [`CORDIC_W-1:0] x_r;
    logic signed [`CORDIC_W-1:0] y_r;
    cordic_pkg::vec_t            next_vec;

    assign x_t = pre_trim(in_vec.x);
    assign y_t = pre_trim(in_vec.y);

    always_comb
    begin
        next_vec.valid = in_vec.valid;
        next_vec.angle = in_vec.angle;
        if (in_vec.z < -`CORDIC_USR_T)
        begin
            x_r        = 128 * x_t - 16 * y_t;
            y_r        = 128 * y_t + 16 * x_t;
            next_vec.z = in_vec.z + `CORDIC_USR_ATAN;
        end
        else if (in_vec.z > `CORDIC_USR_T)
        begin
            x_r        = 128 * x_t + 16 * y_t;
            y_r        = 128 * y_t - 16 * x_t;
            next_vec.z = in_vec.z - `CORDIC_USR_ATAN;
        end
        else
        begin
            x_r        = 129 * x_t;
            y_r        = 129 * y_t;
            next_vec.z = in_vec.z;
        end
        // Second trim is not symmetric between x and y
        next_vec.x = (x_r >>> 7) - (x_r >>> 14);
        next_vec.y = (y_r >>> 7) + (y_r >>> 14);
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            out_vec <= '0;
        end
        else
        begin
            out_vec <= next_vec;
        end
    end

endmodule

//--- tests/cordic_model.svh
`ifndef CORDIC_MODEL_SVH
`define CORDIC_MODEL_SVH

`include "cordic_settings.svh"

// Gain trim ahead of the single-step rotation
function automatic int gain_trim(input int v);
    return (v >>> 5) + (v >>> 6) - (v >>> 8) - (v >>> 9) - (v >>> 10);
endfunction

// Expected rotator output for one input sample worked stage by stage on integers
function automatic cordic_pkg::result_t cordic_model(
    input int x_in,
    input int y_in,
    input int angle_in
);
    int                  xs;
    int                  ys;
    int                  x;
    int                  y;
    int                  z;
    int                  xn;
    int                  a;
    int                  b;
    int                  t;
    int                  m;
    int                  mag;
    cordic_pkg::result_t r;

    xs = x_in * `CORDIC_ANGLE_SCALE;
    ys = y_in * `CORDIC_ANGLE_SCALE;
    z  = angle_in * `CORDIC_ANGLE_SCALE;
    if (angle_in < -135)
    begin
        x = -xs;
        y = -ys;
        z = z + `CORDIC_HALF;
    end
    else if (angle_in < -45)
    begin
        x = -ys;
        y = xs;
        z = z + `CORDIC_QUARTER;
    end
    else if (angle_in < 45)
    begin
        x = xs;
        y = ys;
    end
    else if (angle_in < 135)
    begin
        x = ys;
        y = -xs;
        z = z - `CORDIC_QUARTER;
    end
    else
    begin
        x = -xs;
        y = -ys;
        z = z - `CORDIC_HALF;
    end

    // Pythagorean triples (20,15), (24,7) and plain 25
    if (z >= `CORDIC_FA_T2 || z < -`CORDIC_FA_T2)
    begin
        a = 20;
        b = 15;
        t = `CORDIC_FA_ATAN2;
    end
    else if (z >= `CORDIC_FA_T1 || z < -`CORDIC_FA_T1)
    begin
        a = 24;
        b = 7;
        t = `CORDIC_FA_ATAN1;
    end
    else
    begin
        a = 25;
        b = 0;
        t = 0;
    end
    if (z < 0)
    begin
        xn = a * x - b * y;
        y  = a * y + b * x;
        z  = z + t;
    end
    else
    begin
        xn = a * x + b * y;
        y  = a * y - b * x;
        z  = z - t;
    end
    x = xn;

    x = gain_trim(x);
    y = gain_trim(y);
    if (z < -`CORDIC_USR_T)
    begin
        xn = 128 * x - 16 * y;
        y  = 128 * y + 16 * x;
        z  = z + `CORDIC_USR_ATAN;
    end
    else if (z > `CORDIC_USR_T)
    begin
        xn = 128 * x + 16 * y;
        y  = 128 * y - 16 * x;
        z  = z - `CORDIC_USR_ATAN;
    end
    else
    begin
        xn = 129 * x;
        y  = 129 * y;
    end
    x = (xn >>> 7) - (xn >>> 14);
    y = (y >>> 7) + (y >>> 14);

    for (int s = 5; s <= 7; s++)
    begin
        t = (s == 5) ? `CORDIC_NOM_ATAN5 : (s == 6) ? `CORDIC_NOM_ATAN6 : `CORDIC_NOM_ATAN7;
        if (z < 0)
        begin
            xn = x - (y >>> s);
            y  = y + (x >>> s);
            z  = z + t;
        end
        else
        begin
            xn = x + (y >>> s);
            y  = y - (x >>> s);
            z  = z - t;
        end
        x = xn;
    end

    // Nearest multiple of the step angle with halves rounded away from zero
    mag = (z < 0) ? -z : z;
    m   = (2 * mag + `CORDIC_MICRO_ATAN) / (2 * `CORDIC_MICRO_ATAN);
    if (m > 8)
    begin
        m = 8;
    end
    if (z < 0)
    begin
        m = -m;
    end
    xn = x + m * (y >>> `CORDIC_MICRO_SHIFT);
    y  = y - m * (x >>> `CORDIC_MICRO_SHIFT);
    x  = xn;

    if (angle_in <= -90 || angle_in > 90)
    begin
        x = (x > 0) ? -x : x;
    end
    else
    begin
        x = (x < 0) ? -x : x;
    end
    if (angle_in <= 0)
    begin
        y = (y > 0) ? -y : y;
    end
    else
    begin
        y = (y < 0) ? -y : y;
    end

    r.valid = 1'b1;
    r.x     = x;
    r.y     = y;
    return r;
endfunction

`endif

//--- tests/cordic_rotator_tb.sv
`timescale 1ns/1ps
`include "cordic_settings.svh"

module cordic_rotator_tb;

    localparam int N_DIRECTED   = 36;
    localparam int N_SWEEP      = 361;
    localparam int N_RANDOM     = 300;
    localparam int N_GAPPED     = 150;
    localparam int MAX_GAP      = 3;
    localparam int TOTAL_CYCLES = 4 + 20 + N_DIRECTED + N_SWEEP + N_RANDOM
                                + N_GAPPED * (MAX_GAP + 1) + 4 * (`CORDIC_LATENCY + 4);
    localparam longint WATCHDOG_NS = longint'(TOTAL_CYCLES + `CORDIC_LATENCY + 20) * 100;

    logic                clk = 1'b0;
    logic                rst_n = 1'b0;
    cordic_pkg::sample_t in_sample;
    cordic_pkg::result_t out_result;

    cordic_pkg::result_t exp_q[$];
    int                  angle_q[$];
    int                  due_q[$];
    int                  cycle_cnt = 0;
    int                  n_sent = 0;
    int                  n_received = 0;
    int                  seed;

    `include "cordic_model.svh"

    cordic_rotator dut0 (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_sample  (in_sample),
        .out_result (out_result)
    );

    always #50 clk = ~clk;

    always @(posedge clk)
    begin
        cycle_cnt <= cycle_cnt + 1;
    end

    ////////////////////
    // Failure reporting and checks
    ////////////////////
    task automatic halt_run(input string what);
        $display("%s", what);
        $display("** FAIL **");
        $fatal(1, "Simulation stopped at first error");
    endtask

    task automatic report_mismatch(input string what);
        halt_run($sformatf("CHECK FAILED at %0t ns: %s", $time, what));
    endtask

    task automatic check_result(
        input cordic_pkg::result_t got,
        input cordic_pkg::result_t expected,
        input int                  angle
    );
        if (got !== expected)
        begin
            report_mismatch($sformatf("angle %0d: got (%0d, %0d), expected (%0d, %0d)",
                angle, got.x, got.y, expected.x, expected.y));
        end
    endtask

    task automatic check_valid_idle(input cordic_pkg::result_t got);
        if (got.valid !== 1'b0)
        begin
            report_mismatch($sformatf("valid is %b in cycle %0d with no result due",
                got.valid, cycle_cnt));
        end
    endtask

    // Quadrant rule applied straight from the input angle
    function automatic bit signs_follow_angle(input int x, input int y, input int angle);
        if (angle <= -90)
        begin
            return x <= 0 && y <= 0;
        end
        else if (angle <= 0)
        begin
            return x >= 0 && y <= 0;
        end
        else if (angle <= 90)
        begin
            return x >= 0 && y >= 0;
        end
        return x <= 0 && y >= 0;
    endfunction

    task automatic check_signs(input cordic_pkg::result_t got, input int angle);
        if (!signs_follow_angle(got.x, got.y, angle))
        begin
            report_mismatch($sformatf("angle %0d: signs of (%0d, %0d) break the quadrant rule",
                angle, got.x, got.y));
        end
    endtask

    ////////////////////
    // Stimulus helpers
    ////////////////////
    task automatic drive_sample(input logic valid, input int x, input int y, input int angle);
        @(posedge clk);
        #1;
        in_sample.valid = valid;
        in_sample.x     = `CORDIC_IN_W'(x);
        in_sample.y     = `CORDIC_IN_W'(y);
        in_sample.angle = `CORDIC_IN_W'(angle);
        if (valid)
        begin
            exp_q.push_back(cordic_model(int'(in_sample.x), int'(in_sample.y),
                int'(in_sample.angle)));
            angle_q.push_back(int'(in_sample.angle));
            due_q.push_back(cycle_cnt + `CORDIC_LATENCY);
            n_sent++;
        end
    endtask

    task automatic drive_random(input logic valid);
        int x;
        int y;
        int angle;

        x     = $random(seed) % 256;
        y     = $random(seed) % 256;
        angle = $random(seed) % 181;
        drive_sample(valid, x, y, angle);
    endtask

    task automatic wait_for_drain();
        int waited;

        waited = 0;
        while (due_q.size() > 0 && waited < `CORDIC_LATENCY + 4)
        begin
            @(posedge clk);
            waited++;
        end
        if (due_q.size() > 0)
        begin
            halt_run($sformatf("%0d results still missing after %0d cycles",
                due_q.size(), waited));
        end
    endtask

    // Compare process on the falling edge
    always @(negedge clk)
    begin
        if (rst_n)
        begin
            if (out_result.valid === 1'b1)
            begin
                n_received++;
            end
            if (due_q.size() > 0 && due_q[0] == cycle_cnt)
            begin
                if (out_result.valid !== 1'b1)
                begin
                    halt_run($sformatf("Result for angle %0d did not arrive in cycle %0d",
                        angle_q[0], cycle_cnt));
                end
                else
                begin
                    check_signs(out_result, angle_q[0]);
                    check_result(out_result, exp_q[0], angle_q[0]);
                    void'(exp_q.pop_front());
                    void'(angle_q.pop_front());
                    void'(due_q.pop_front());
                end
            end
            else
            begin
                check_valid_idle(out_result);
            end
        end
    end

    initial
    begin
        #(WATCHDOG_NS);
        halt_run($sformatf("Watchdog expired after %0d ns with %0d of %0d results seen",
            WATCHDOG_NS, n_received, n_sent));
    end

    initial
    begin
        int dir_angles [9];
        int gap;

        seed      = 32'h7c83;
        in_sample = '0;
        rst_n     = 1'b0;
        repeat (4) @(posedge clk);
        #1;
        rst_n = 1'b1;

        // Idle output after reset
        repeat (20) @(posedge clk);

        dir_angles = '{0, 45, -45, 90, -90, 135, -135, 180, -180};
        foreach (dir_angles[i])
        begin
            drive_sample(1'b1, 200, 0, dir_angles[i]);
            drive_sample(1'b1, 0, 200, dir_angles[i]);
            drive_sample(1'b1, -200, 0, dir_angles[i]);
            drive_sample(1'b1, 0, -200, dir_angles[i]);
        end
        drive_sample(1'b0, 0, 0, 0);
        wait_for_drain();

        // Full angle sweep, back to back
        for (int ang = -180; ang <= 180; ang++)
        begin
            drive_sample(1'b1, 100, 0, ang);
        end
        drive_sample(1'b0, 0, 0, 0);
        wait_for_drain();

        for (int i = 0; i < N_RANDOM; i++)
        begin
            drive_random(1'b1);
        end
        drive_sample(1'b0, 0, 0, 0);
        wait_for_drain();
        if (n_received != n_sent)
        begin
            halt_run($sformatf("Random burst gave %0d results for %0d samples",
                n_received, n_sent));
        end

        // Gaps carry random data with valid low
        for (int i = 0; i < N_GAPPED; i++)
        begin
            drive_random(1'b1);
            gap = $random(seed) & MAX_GAP;
            repeat (gap) drive_random(1'b0);
        end
        drive_sample(1'b0, 0, 0, 0);
        wait_for_drain();

        if (exp_q.size() != 0 || n_received != n_sent)
        begin
            halt_run($sformatf("Run ended with %0d results for %0d samples",
                n_received, n_sent));
        end
        else
        begin
            $display("** PASS **");
            $finish;
        end
    end

endmodule
